//--- design/sys_macros.svh
// Command codes of the host I/O bus
// Reset values for video size, volume and the sync counter width
`ifndef SYS_MACROS_SVH
`define SYS_MACROS_SVH

////////////////////
// Host commands
`define SYS_CMD_CFG        8'h01
`define SYS_CMD_VMODE      8'h20
`define SYS_CMD_LED        8'h25
`define SYS_CMD_VOL        8'h26
`define SYS_CMD_VSET       8'h27
`define SYS_CMD_HSET       8'h37

// Answer code on io_dout after the video mode command byte
`define SYS_VMODE_ACK      16'd3

////////////////////
// Reset values
`define SYS_DEF_WIDTH      12'd1920
`define SYS_DEF_HEIGHT     12'd1080
`define SYS_VOL_ATT_RESET  5'b11111

// Configuration word bit selecting composite sync on hsync
`define SYS_CFG_CSYNC_BIT  3

////////////////////
// Widths
`define SYS_SYNC_CNT_W     16

`endif

//--- design/sys_pkg.sv
// Shared vector types of the system control block
// and the state encoding of the output window calculator

package sys_pkg;

	////////////////////
	// Bus words
	typedef logic [15:0] cmd_word_t;
	typedef logic [7:0]  cmd_code_t;

	////////////////////
	// Video geometry
	// Pixel or line count
	typedef logic [11:0] dim_t;
	// Aspect component, top bit reserved
	typedef logic [12:0] aspect_t;

	////////////////////
	// Audio and LEDs
	typedef logic [4:0] vol_att_t;
	typedef logic [7:0] led_byte_t;

	// Window calculator sequence
	typedef enum logic [2:0] {
		IDLE,
		MUL_W,
		WAIT_W,
		MUL_H,
		WAIT_H,
		CLAMP,
		CENTRE
	} win_state_e;

endpackage

//--- design/video_cfg_if.sv
// Video size and scale limits set by the host
// Decoder drives src, window calculator reads dst
`timescale 1ns/1ps

interface video_cfg_if;

	// Mode size from the video mode command
	sys_pkg::dim_t width;
	sys_pkg::dim_t height;

	// Output scale limits, zero means no limit
	sys_pkg::dim_t vset;
	sys_pkg::dim_t hset;
	logic          freescale;

	modport src (
		output width,
		output height,
		output vset,
		output hset,
		output freescale
	);

	modport dst (
		input width,
		input height,
		input vset,
		input hset,
		input freescale
	);

endinterface

//--- design/hps_cmd_decoder.sv
// Host I/O bus command decoder
// Holds configuration, LED, volume and video size registers
// and the readback word
`timescale 1ns/1ps
`include "sys_macros.svh"

module hps_cmd_decoder (
	input  logic               arst_n_i,
	input  logic               clk_sys,

	input  logic               io_uio_i,
	input  logic               io_strobe_i,
	input  sys_pkg::cmd_word_t io_din_i,
	output sys_pkg::cmd_word_t io_dout_o,

	output sys_pkg::cmd_word_t cfg_o,
	output sys_pkg::led_byte_t led_overtake_o,
	output sys_pkg::led_byte_t led_state_o,
	output sys_pkg::vol_att_t  vol_att_o,

	video_cfg_if.src           vcfg
);

	logic               has_cmd;
	sys_pkg::cmd_code_t cmd;
	sys_pkg::cmd_code_t din_code;
	// Parameter word index, saturates
	logic [3:0]         cnt;

	assign din_code = io_din_i[7:0];

	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			has_cmd         <= 1'b0;
			cmd             <= '0;
			cnt             <= '0;
			io_dout_o       <= '0;
			cfg_o           <= '0;
			led_overtake_o  <= '0;
			led_state_o     <= '0;
			vol_att_o       <= `SYS_VOL_ATT_RESET;
			vcfg.width      <= `SYS_DEF_WIDTH;
			vcfg.height     <= `SYS_DEF_HEIGHT;
			vcfg.vset       <= '0;
			vcfg.hset       <= '0;
			vcfg.freescale  <= 1'b0;
		end else if (!io_uio_i) begin
			// Bus deselected, drop any pending command
			has_cmd   <= 1'b0;
			io_dout_o <= '0;
		end else if (io_strobe_i) begin
			io_dout_o <= '0;
			if (!has_cmd) begin
				////////////////////
				// Command byte
				has_cmd <= 1'b1;
				cmd     <= din_code;
				cnt     <= '0;
				if (din_code == `SYS_CMD_VMODE) begin
					io_dout_o <= `SYS_VMODE_ACK;
				end
			end else begin
				////////////////////
				// Parameter words
				if (!(&cnt)) begin
					cnt <= cnt + 1'b1;
				end
				case (cmd)
					`SYS_CMD_CFG: begin
						cfg_o <= io_din_i;
					end
					`SYS_CMD_VMODE: begin
						// Only width and height are kept
						if (cnt == 4'd0) begin
							vcfg.width <= io_din_i[11:0];
						end
						if (cnt == 4'd4) begin
							vcfg.height <= io_din_i[11:0];
						end
					end
					`SYS_CMD_LED: begin
						led_overtake_o <= io_din_i[15:8];
						led_state_o    <= io_din_i[7:0];
					end
					`SYS_CMD_VOL: begin
						vol_att_o <= io_din_i[4:0];
					end
					`SYS_CMD_VSET: begin
						vcfg.vset <= io_din_i[11:0];
					end
					`SYS_CMD_HSET: begin
						vcfg.freescale <= io_din_i[15];
						vcfg.hset      <= io_din_i[11:0];
					end
					default: begin
						// Unknown commands swallow their words
					end
				endcase
			end
		end
	end

endmodule

//--- design/umuldiv.sv
// Sequential unsigned multiply then divide
// Product latched at start, restoring division one bit per cycle
`timescale 1ns/1ps

module umuldiv (
	input  logic          arst_n_i,
	input  logic          clk_sys,
	input  logic          start_i,
	input  sys_pkg::dim_t mul1_i,
	input  sys_pkg::dim_t mul2_i,
	input  sys_pkg::dim_t div_i,
	output logic          busy_o,
	output sys_pkg::dim_t result_o
);

	localparam int DIM_W  = $bits(sys_pkg::dim_t);
	localparam int PROD_W = 2 * DIM_W;
	localparam int CNT_W  = $clog2(PROD_W + 1);

	// Dividend shifts out on top, quotient shifts in at the bottom
	logic [PROD_W-1:0] acc;
	sys_pkg::dim_t     rem;
	sys_pkg::dim_t     divisor;
	logic [CNT_W-1:0]  bit_cnt;
	logic [DIM_W:0]    rem_sh;
	logic [DIM_W:0]    rem_diff;
	logic              launch;

	assign launch   = start_i & ~busy_o;
	assign rem_sh   = {rem, acc[PROD_W-1]};
	assign rem_diff = rem_sh - {1'b0, divisor};
	assign result_o = acc[DIM_W-1:0];

	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			busy_o  <= 1'b0;
			bit_cnt <= '0;
		end else if (launch) begin
			busy_o  <= 1'b1;
			bit_cnt <= CNT_W'(PROD_W);
		end else if (busy_o) begin
			bit_cnt <= bit_cnt - 1'b1;
			if (bit_cnt == CNT_W'(1)) begin
				busy_o <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (launch) begin
			acc     <= mul1_i * mul2_i;
			rem     <= '0;
			divisor <= div_i;
		end else if (busy_o) begin
			// No borrow means the divisor fits
			if (!rem_diff[DIM_W]) begin
				rem <= rem_diff[DIM_W-1:0];
				acc <= {acc[PROD_W-2:0], 1'b1};
			end else begin
				rem <= rem_sh[DIM_W-1:0];
				acc <= {acc[PROD_W-2:0], 1'b0};
			end
		end
	end

endmodule

//--- design/scaler_window_calc.sv
// Output window calculator for the scaler
// Fits the core aspect ratio into the output frame and centres it
`timescale 1ns/1ps

module scaler_window_calc (
	input  logic            arst_n_i,
	input  logic            clk_sys,
	video_cfg_if.dst        vcfg,
	input  sys_pkg::aspect_t ar_x_i,
	input  sys_pkg::aspect_t ar_y_i,
	output sys_pkg::dim_t   hmin_o,
	output sys_pkg::dim_t   hmax_o,
	output sys_pkg::dim_t   vmin_o,
	output sys_pkg::dim_t   vmax_o
);

	sys_pkg::win_state_e state;

	// Output frame after scale limits
	sys_pkg::dim_t out_w;
	sys_pkg::dim_t out_h;
	sys_pkg::dim_t wcalc;
	sys_pkg::dim_t hcalc;
	sys_pkg::dim_t videow;
	sys_pkg::dim_t videoh;
	sys_pkg::dim_t arx;
	sys_pkg::dim_t ary;

	logic          md_start;
	logic          md_busy;
	sys_pkg::dim_t md_mul1;
	sys_pkg::dim_t md_mul2;
	sys_pkg::dim_t md_div;
	sys_pkg::dim_t md_res;

	// Bit 12 of the aspect is reserved
	assign arx = ar_x_i[11:0];
	assign ary = ar_y_i[11:0];

	umuldiv u_muldiv (
		.arst_n_i (arst_n_i),
		.clk_sys  (clk_sys),
		.start_i  (md_start),
		.mul1_i   (md_mul1),
		.mul2_i   (md_mul2),
		.div_i    (md_div),
		.busy_o   (md_busy),
		.result_o (md_res)
	);

	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state    <= sys_pkg::IDLE;
			out_w    <= '0;
			out_h    <= '0;
			wcalc    <= '0;
			hcalc    <= '0;
			videow   <= '0;
			videoh   <= '0;
			md_start <= 1'b0;
			md_mul1  <= '0;
			md_mul2  <= '0;
			md_div   <= '0;
			hmin_o   <= '0;
			hmax_o   <= '0;
			vmin_o   <= '0;
			vmax_o   <= '0;
		end else begin
			out_w    <= (vcfg.hset != '0 && vcfg.hset < vcfg.width) ? vcfg.hset : vcfg.width;
			out_h    <= (vcfg.vset != '0 && vcfg.vset < vcfg.height) ? vcfg.vset : vcfg.height;
			md_start <= 1'b0;

			case (state)
				sys_pkg::IDLE: begin
					if (vcfg.freescale || arx == '0 || ary == '0) begin
						wcalc <= out_w;
						hcalc <= out_h;
						state <= sys_pkg::CLAMP;
					end else begin
						state <= sys_pkg::MUL_W;
					end
				end
				////////////////////
				// Width from output height
				sys_pkg::MUL_W: begin
					md_mul1  <= out_h;
					md_mul2  <= arx;
					md_div   <= ary;
					md_start <= 1'b1;
					state    <= sys_pkg::WAIT_W;
				end
				sys_pkg::WAIT_W: begin
					if (!md_start && !md_busy) begin
						wcalc <= md_res;
						state <= sys_pkg::MUL_H;
					end
				end
				////////////////////
				// Height from output width
				sys_pkg::MUL_H: begin
					md_mul1  <= out_w;
					md_mul2  <= ary;
					md_div   <= arx;
					md_start <= 1'b1;
					state    <= sys_pkg::WAIT_H;
				end
				sys_pkg::WAIT_H: begin
					if (!md_start && !md_busy) begin
						hcalc <= md_res;
						state <= sys_pkg::CLAMP;
					end
				end
				sys_pkg::CLAMP: begin
					videow <= (wcalc > out_w) ? out_w : wcalc;
					videoh <= (hcalc > out_h) ? out_h : hcalc;
					state  <= sys_pkg::CENTRE;
				end
				sys_pkg::CENTRE: begin
					// Centre inside the mode frame
					hmin_o <= (vcfg.width - videow) >> 1;
					hmax_o <= ((vcfg.width - videow) >> 1) + videow - 1'b1;
					vmin_o <= (vcfg.height - videoh) >> 1;
					vmax_o <= ((vcfg.height - videoh) >> 1) + videoh - 1'b1;
					state  <= sys_pkg::IDLE;
				end
				default: begin
					state <= sys_pkg::IDLE;
				end
			endcase
		end
	end

endmodule

//--- design/sync_polarity_fix.sv
// Sync polarity normaliser
// Compares high and low run lengths, flips to an active-high pulse
`timescale 1ns/1ps
`include "sys_macros.svh"

module sync_polarity_fix (
	input  logic arst_n_i,
	input  logic clk_sys,
	input  logic sync_i,
	output logic sync_o
);

	logic                       sync_d;
	logic                       pol;
	logic [`SYS_SYNC_CNT_W-1:0] run_cnt;
	logic [`SYS_SYNC_CNT_W-1:0] high_len;
	logic [`SYS_SYNC_CNT_W-1:0] low_len;

	assign sync_o = sync_i ^ pol;

	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			sync_d   <= 1'b0;
			pol      <= 1'b0;
			run_cnt  <= '0;
			high_len <= '0;
			low_len  <= '0;
		end else begin
			sync_d <= sync_i;
			if (sync_d != sync_i) begin
				run_cnt <= '0;
			end else if (!(&run_cnt)) begin
				run_cnt <= run_cnt + 1'b1;
			end
			// Run that just ended
			if (sync_i && !sync_d) begin
				low_len <= run_cnt;
			end
			if (!sync_i && sync_d) begin
				high_len <= run_cnt;
			end
			// Longer high run means active-low input
			pol <= high_len > low_len;
		end
	end

endmodule

//--- design/csync_gen.sv
// Composite sync generator
// Serrated vsync with pulses moved ahead of each hsync
`timescale 1ns/1ps
`include "sys_macros.svh"

module csync_gen (
	input  logic arst_n_i,
	input  logic clk_sys,
	input  logic hsync_i,
	input  logic vsync_i,
	output logic csync_o
);

	logic                       prev_hs;
	logic [`SYS_SYNC_CNT_W-1:0] h_cnt;
	logic [`SYS_SYNC_CNT_W-1:0] hs_len;
	// Count in the low run where the serration starts
	logic [`SYS_SYNC_CNT_W-1:0] line_len;

	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			prev_hs  <= 1'b0;
			h_cnt    <= '0;
			hs_len   <= '0;
			line_len <= '0;
			csync_o  <= 1'b0;
		end else begin
			prev_hs <= hsync_i;
			h_cnt   <= h_cnt + 1'b1;
			if (prev_hs != hsync_i) begin
				h_cnt <= '0;
				if (hsync_i) begin
					line_len <= h_cnt - hs_len;
				end else begin
					hs_len <= h_cnt + 1'b1;
				end
			end

			if (!vsync_i) begin
				csync_o <= hsync_i;
			end else if (hsync_i && !prev_hs) begin
				csync_o <= 1'b1;
			end else if (!hsync_i && h_cnt == line_len) begin
				csync_o <= 1'b0;
			end
		end
	end

endmodule

//--- design/sys_top.sv
// System control top
// Command decoder, output window, sync clean-up and LED mixer
`timescale 1ns/1ps
`include "sys_macros.svh"

module sys_top (
	input  logic               arst_n_i,
	input  logic               clk_sys,

	input  logic               io_uio_i,
	input  logic               io_strobe_i,
	input  sys_pkg::cmd_word_t io_din_i,
	output sys_pkg::cmd_word_t io_dout_o,

	input  sys_pkg::aspect_t   ar_x_i,
	input  sys_pkg::aspect_t   ar_y_i,

	input  sys_pkg::led_byte_t core_led_i,
	output sys_pkg::led_byte_t led_o,
	output sys_pkg::vol_att_t  vol_att_o,

	input  logic               hs_i,
	input  logic               vs_i,
	output logic               hs_o,
	output logic               vs_o,

	output sys_pkg::dim_t      hmin_o,
	output sys_pkg::dim_t      hmax_o,
	output sys_pkg::dim_t      vmin_o,
	output sys_pkg::dim_t      vmax_o
);

	video_cfg_if vcfg ();

	sys_pkg::cmd_word_t cfg;
	sys_pkg::led_byte_t led_overtake;
	sys_pkg::led_byte_t led_state;
	logic               hs_fix;
	logic               vs_fix;
	logic               cs_fix;

	hps_cmd_decoder u_decoder (
		.arst_n_i       (arst_n_i),
		.clk_sys        (clk_sys),
		.io_uio_i       (io_uio_i),
		.io_strobe_i    (io_strobe_i),
		.io_din_i       (io_din_i),
		.io_dout_o      (io_dout_o),
		.cfg_o          (cfg),
		.led_overtake_o (led_overtake),
		.led_state_o    (led_state),
		.vol_att_o      (vol_att_o),
		.vcfg           (vcfg.src)
	);

	scaler_window_calc u_window (
		.arst_n_i (arst_n_i),
		.clk_sys  (clk_sys),
		.vcfg     (vcfg.dst),
		.ar_x_i   (ar_x_i),
		.ar_y_i   (ar_y_i),
		.hmin_o   (hmin_o),
		.hmax_o   (hmax_o),
		.vmin_o   (vmin_o),
		.vmax_o   (vmax_o)
	);

	////////////////////
	// Sync path
	sync_polarity_fix u_hs_fix (
		.arst_n_i (arst_n_i),
		.clk_sys  (clk_sys),
		.sync_i   (hs_i),
		.sync_o   (hs_fix)
	);

	sync_polarity_fix u_vs_fix (
		.arst_n_i (arst_n_i),
		.clk_sys  (clk_sys),
		.sync_i   (vs_i),
		.sync_o   (vs_fix)
	);

	csync_gen u_csync (
		.arst_n_i (arst_n_i),
		.clk_sys  (clk_sys),
		.hsync_i  (hs_fix),
		.vsync_i  (vs_fix),
		.csync_o  (cs_fix)
	);

	assign hs_o = cfg[`SYS_CFG_CSYNC_BIT] ? cs_fix : hs_fix;
	assign vs_o = vs_fix;

	////////////////////
	// Main-board LEDs, driven active low
	assign led_o = ~((led_overtake & led_state) | (~led_overtake & core_led_i));

endmodule

//--- verif/tb_sys_top.sv
// Directed testbench for the system control top
// Host bus tasks, LED, volume, window and sync path tests
`timescale 1ns/1ps
`include "sys_macros.svh"

module tb_sys_top;

	localparam int CLK_PERIOD  = 100;
	// Tests take about 4000 cycles
	localparam int CYCLE_LIMIT = 20000;
	localparam int SETTLE      = 200;

	////////////////////
	// Sync stimulus geometry
	localparam int LINE_LEN    = 40;
	localparam int HS_WIDTH    = 6;
	localparam int FRAME_LINES = 8;
	localparam int VS_LINES    = 3;
	localparam int FRAME_LEN   = LINE_LEN * FRAME_LINES;

	logic             clk_sys;
	logic             arst_n_i;
	logic             io_uio_i;
	logic             io_strobe_i;
	logic [15:0]      io_din_i;
	logic [15:0]      io_dout_o;
	logic [12:0]      ar_x_i;
	logic [12:0]      ar_y_i;
	logic [7:0]       core_led_i;
	logic [7:0]       led_o;
	logic [4:0]       vol_att_o;
	logic             hs_i = 1'b1;
	logic             vs_i = 1'b1;
	logic             hs_o;
	logic             vs_o;
	logic [11:0]      hmin_o;
	logic [11:0]      hmax_o;
	logic [11:0]      vmin_o;
	logic [11:0]      vmax_o;

	int   seed      = 32'h6a593514;
	int   cycle_cnt = 0;
	logic sync_run;
	int   sync_pos  = LINE_LEN - 1;
	int   sync_line = FRAME_LINES - 1;

	sys_top uut (
		.arst_n_i    (arst_n_i),
		.clk_sys     (clk_sys),
		.io_uio_i    (io_uio_i),
		.io_strobe_i (io_strobe_i),
		.io_din_i    (io_din_i),
		.io_dout_o   (io_dout_o),
		.ar_x_i      (ar_x_i),
		.ar_y_i      (ar_y_i),
		.core_led_i  (core_led_i),
		.led_o       (led_o),
		.vol_att_o   (vol_att_o),
		.hs_i        (hs_i),
		.vs_i        (vs_i),
		.hs_o        (hs_o),
		.vs_o        (vs_o),
		.hmin_o      (hmin_o),
		.hmax_o      (hmax_o),
		.vmin_o      (vmin_o),
		.vmax_o      (vmax_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Run stopped because the cycle limit of %0d was reached", CYCLE_LIMIT);
			$display("tests failed");
			$fatal(1, "timeout");
		end
	end

	// Active-low core syncs, vsync on the first lines of each frame
	always @(posedge clk_sys) begin
		#1;
		if (sync_run) begin
			if (sync_pos == LINE_LEN - 1) begin
				sync_pos  = 0;
				sync_line = (sync_line == FRAME_LINES - 1) ? 0 : sync_line + 1;
			end else begin
				sync_pos = sync_pos + 1;
			end
			hs_i = !(sync_pos < HS_WIDTH);
			vs_i = !(sync_line < VS_LINES);
		end
	end

	////////////////////
	// Helpers
	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("[FAIL] time %0t: %s (got %0d, expected %0d)",
				$time, what, actual, expected);
			$display("tests failed");
			$fatal(1, "check failed");
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
		#1;
	endtask

	// One-cycle strobe carrying a word
	task automatic write_word(input logic [15:0] word);
		@(posedge clk_sys);
		#1;
		io_strobe_i = 1'b1;
		io_din_i    = word;
		@(posedge clk_sys);
		#1;
		io_strobe_i = 1'b0;
	endtask

	task automatic select_command(input logic [7:0] code);
		@(posedge clk_sys);
		#1;
		io_uio_i = 1'b1;
		write_word({8'h00, code});
	endtask

	task automatic release_bus();
		@(posedge clk_sys);
		#1;
		io_uio_i = 1'b0;
	endtask

	task automatic send_short_command(input logic [7:0] code, input logic [15:0] word);
		select_command(code);
		write_word(word);
		release_bus();
	endtask

	// Width in word 0, height in word 4, porch and sync words left at zero
	task automatic set_video_mode(input int w, input int h);
		select_command(`SYS_CMD_VMODE);
		check_value(32'(io_dout_o), 3, "video mode ready code");
		write_word(16'(w));
		check_value(32'(io_dout_o), 0, "readback cleared by parameter word");
		repeat (3) write_word(16'h0000);
		write_word(16'(h));
		repeat (3) write_word(16'h0000);
		release_bus();
	endtask

	function automatic logic [7:0] mixed_led(input logic [7:0] ovt, input logic [7:0] state,
		input logic [7:0] core);
		logic [7:0] res;
		for (int i = 0; i < 8; i++) begin
			res[i] = ovt[i] ? !state[i] : !core[i];
		end
		return res;
	endfunction

	// Expected window from the mode size, limits and aspect
	task automatic check_window(input int mode_w, input int mode_h, input int vset,
		input int hset, input bit free, input int ax, input int ay);
		int out_w;
		int out_h;
		int cont_w;
		int cont_h;
		int hmin;
		int vmin;
		out_w = (hset != 0 && hset < mode_w) ? hset : mode_w;
		out_h = (vset != 0 && vset < mode_h) ? vset : mode_h;
		if (free || ax == 0 || ay == 0) begin
			cont_w = out_w;
			cont_h = out_h;
		end else begin
			cont_w = out_h * ax / ay;
			cont_h = out_w * ay / ax;
			cont_w = (cont_w > out_w) ? out_w : cont_w;
			cont_h = (cont_h > out_h) ? out_h : cont_h;
		end
		hmin = (mode_w - cont_w) / 2;
		vmin = (mode_h - cont_h) / 2;
		wait_cycles(SETTLE);
		check_value(32'(hmin_o), hmin, "hmin");
		check_value(32'(hmax_o), hmin + cont_w - 1, "hmax");
		check_value(32'(vmin_o), vmin, "vmin");
		check_value(32'(vmax_o), vmin + cont_h - 1, "vmax");
	endtask

	////////////////////
	// Directed tests
	task automatic reset_defaults();
		check_value(32'(led_o), 32'(mixed_led(8'h00, 8'h00, core_led_i)), "LED after reset");
		check_value(32'(vol_att_o), 32'h1f, "attenuation after reset");
		check_window(1920, 1080, 0, 0, 1'b0, 0, 0);
	endtask

	task automatic led_and_volume();
		logic [7:0] ovt;
		logic [7:0] state;
		ovt   = 8'hf0;
		state = 8'b1010_0110;
		send_short_command(`SYS_CMD_LED, {ovt, state});
		check_value(32'(led_o), 32'(mixed_led(ovt, state, core_led_i)), "LED overtake");
		core_led_i = 8'($random(seed));
		@(negedge clk_sys);
		check_value(32'(led_o), 32'(mixed_led(ovt, state, core_led_i)), "LED with new core");
		send_short_command(`SYS_CMD_VOL, 16'h0009);
		check_value(32'(vol_att_o), 32'h09, "attenuation");
		// Bus deselected, no strobe may answer or store
		write_word({8'h00, `SYS_CMD_VMODE});
		check_value(32'(io_dout_o), 0, "readback with bus deselected");
		write_word({8'h00, `SYS_CMD_VOL});
		write_word(16'h0015);
		check_value(32'(vol_att_o), 32'h09, "attenuation with bus deselected");
		send_short_command(`SYS_CMD_VOL, 16'h0015);
		check_value(32'(vol_att_o), 32'h15, "attenuation after reselect");
	endtask

	task automatic video_mode_size();
		// Ready code dropped together with the pending command on release
		select_command(`SYS_CMD_VMODE);
		release_bus();
		wait_cycles(1);
		check_value(32'(io_dout_o), 0, "readback after release");
		set_video_mode(800, 600);
		check_window(800, 600, 0, 0, 1'b0, 0, 0);
	endtask

	task automatic aspect_and_limits();
		set_video_mode(1920, 1080);
		ar_x_i = 13'd4;
		ar_y_i = 13'd3;
		check_window(1920, 1080, 0, 0, 1'b0, 4, 3);
		send_short_command(`SYS_CMD_VSET, 16'd540);
		check_window(1920, 1080, 540, 0, 1'b0, 4, 3);
		send_short_command(`SYS_CMD_VSET, 16'd0);
		send_short_command(`SYS_CMD_HSET, 16'h8000 | 16'd1280);
		check_window(1920, 1080, 0, 1280, 1'b1, 4, 3);
	endtask

	task automatic sync_path();
		int   run_len;
		int   pulses;
		logic prev_hs;
		logic in_run;
		sync_run = 1'b1;
		wait_cycles(3 * FRAME_LEN);
		repeat (FRAME_LEN) begin
			@(negedge clk_sys);
			check_value(32'(hs_o), 32'(!hs_i), "hs_o active-high");
			check_value(32'(vs_o), 32'(!vs_i), "vs_o active-high");
		end
		send_short_command(`SYS_CMD_CFG, 16'h0001 << `SYS_CFG_CSYNC_BIT);
		wait_cycles(2 * FRAME_LEN);
		run_len = 0;
		pulses  = 0;
		prev_hs = 1'b0;
		in_run  = 1'b0;
		// Low runs of hs_o that start inside vsync
		repeat (2 * FRAME_LEN) begin
			@(negedge clk_sys);
			if (in_run) begin
				if (hs_o) begin
					check_value(run_len, HS_WIDTH, "serration pulse width");
					pulses = pulses + 1;
					in_run = 1'b0;
				end else begin
					run_len = run_len + 1;
				end
			end else if (prev_hs && !hs_o && vs_o) begin
				in_run  = 1'b1;
				run_len = 1;
			end
			prev_hs = hs_o;
		end
		check_value(32'(pulses >= VS_LINES), 1, "serration pulses seen");
	endtask

	initial begin
		arst_n_i    = 1'b0;
		io_uio_i    = 1'b0;
		io_strobe_i = 1'b0;
		io_din_i    = '0;
		ar_x_i      = '0;
		ar_y_i      = '0;
		core_led_i  = 8'($random(seed));
		sync_run    = 1'b0;
		repeat (10) @(posedge clk_sys);
		#1;
		arst_n_i = 1'b1;

		reset_defaults();
		led_and_volume();
		video_mode_size();
		aspect_and_limits();
		sync_path();

		$display("all tests passed");
		$finish;
	end

endmodule

//--- sys_top.f
+incdir+design
design/sys_pkg.sv
design/video_cfg_if.sv
design/hps_cmd_decoder.sv
design/umuldiv.sv
design/scaler_window_calc.sv
design/sync_polarity_fix.sv
design/csync_gen.sv
design/sys_top.sv
verif/tb_sys_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f sys_top.f --top-module tb_sys_top -o tb_sys_top
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_sys_top > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -qx "all tests passed" "$LOG"; then
	exit 0
fi
echo "Simulation failed (exit status $run_status)"
exit 1
